/* Makefile */
TOP := wb_subsystem_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 --top-module $(TOP) -f wb_subsystem.f -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module wb_subsystem -f wb_subsystem.f

clean:
	rm -rf obj_dir

/* csr_file.sv */
module csr_file #(
    parameter logic [31:0] eentry_reset = 32'h1c00_8000
) (
    input  logic               clk,
    input  logic               reset,
    // committed csr write
    input  csr_pkg::csr_ctrl_t csr_wr,
    input  logic               csr_commit,
    // exception entry / return
    input  logic               excp_flush,
    input  logic               ertn_flush,
    input  logic [31:0]        excp_era,
    input  logic [5:0]         ecode,
    input  logic [8:0]         esubcode,
    // read port and redirect
    input  logic [13:0]        rd_num,
    output logic [31:0]        rd_data,
    output logic [31:0]        redirect_pc
);

    logic [31:0] crmd;    // [1:0] plv, [2] ie
    logic [31:0] prmd;    // [1:0] pplv, [2] pie
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] estat;   // [21:16] ecode, [30:22] esubcode

    logic        wr_en;
    logic [31:0] wr_old;  // current value of the written csr
    logic [31:0] wr_val;

    // read mux, unknown numbers give zero
    function automatic logic [31:0] csr_value(input logic [13:0] num);
        logic [31:0] val;
        unique case (num)
            csr_pkg::csr_num_crmd:   val = crmd;
            csr_pkg::csr_num_prmd:   val = prmd;
            csr_pkg::csr_num_estat:  val = estat;
            csr_pkg::csr_num_era:    val = era;
            csr_pkg::csr_num_eentry: val = eentry;
            default:                 val = 32'h0;
        endcase
        return val;
    endfunction

    always_comb begin
        rd_data = csr_value(rd_num);
        wr_old  = csr_value(csr_wr.csr_num);
    end

    assign wr_en = csr_commit & csr_wr.csr_we & (csr_wr.csr_op != csr_pkg::csr_op_none);

    // xchg keeps the bits outside the mask
    assign wr_val = (csr_wr.csr_op == csr_pkg::csr_op_xchg) ?
                    ((wr_old & ~csr_wr.wmask) | (csr_wr.wdata & csr_wr.wmask)) :
                    csr_wr.wdata;

    // exception target first, else return address
    assign redirect_pc = excp_flush ? eentry : era;

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd   <= 32'h0;  // plv 0, ie 0
            prmd   <= 32'h0;
            era    <= 32'h0;
            eentry <= eentry_reset;
            estat  <= 32'h0;
        end else begin
            if (wr_en) begin
                case (csr_wr.csr_num)
                    csr_pkg::csr_num_crmd:   crmd   <= wr_val;
                    csr_pkg::csr_num_prmd:   prmd   <= wr_val;
                    csr_pkg::csr_num_era:    era    <= wr_val;
                    csr_pkg::csr_num_eentry: eentry <= wr_val;
                    default: ;  // estat only changes on entry
                endcase
            end
            // entry / return come last so they override a same-cycle write
            if (excp_flush) begin
                prmd[2:0]   <= crmd[2:0];  // save plv and ie
                crmd[2:0]   <= 3'b000;     // kernel, irq off
                era         <= excp_era;
                estat[21:16] <= ecode;
                estat[30:22] <= esubcode;
            end else if (ertn_flush) begin
                crmd[2:0] <= prmd[2:0];
            end
        end
    end

endmodule

/* csr_pkg.sv */
package csr_pkg;

    // csr access kind
    typedef enum logic [1:0] {
        csr_op_none = 2'd0,
        csr_op_wr   = 2'd1,  // plain write
        csr_op_xchg = 2'd2   // masked write
    } csr_op_t;

    typedef struct packed {
        logic        csr_we;
        csr_op_t     csr_op;
        logic [13:0] csr_num;
        logic [31:0] wdata;
        logic [31:0] wmask;   // only looked at for xchg
    } csr_ctrl_t;

    // csr numbers
    localparam logic [13:0] csr_num_crmd   = 14'h0;
    localparam logic [13:0] csr_num_prmd   = 14'h1;
    localparam logic [13:0] csr_num_estat  = 14'h5;
    localparam logic [13:0] csr_num_era    = 14'h6;
    localparam logic [13:0] csr_num_eentry = 14'hc;

    // estat ecode values
    localparam logic [5:0] ecode_sys = 6'hb;
    localparam logic [5:0] ecode_brk = 6'hc;
    localparam logic [5:0] ecode_ine = 6'hd;
    localparam logic [5:0] ecode_ipe = 6'he;
    localparam logic [5:0] ecode_ale = 6'h9;

    // positions inside excp_num
    // lower bits are int / fetch-side tlb, upper ones data-side tlb
    localparam int unsigned excp_bit_sys = 5;
    localparam int unsigned excp_bit_brk = 6;
    localparam int unsigned excp_bit_ine = 7;
    localparam int unsigned excp_bit_ipe = 8;
    localparam int unsigned excp_bit_ale = 9;

endpackage

/* mem_load_align.sv */
module mem_load_align (
    input  logic                 clk,
    input  logic                 reset,
    // from memory stage
    input  logic                 in_valid,
    output logic                 in_ready,
    input  pipe_pkg::mem_in_t    in_bus,
    input  csr_pkg::csr_ctrl_t   in_csr,
    // towards writeback
    output logic                 out_valid,
    input  logic                 out_ready,
    output pipe_pkg::mem_ctrl_t  out_ctrl,
    output pipe_pkg::mem_excp_t  out_excp,
    output csr_pkg::csr_ctrl_t   out_csr
);

    logic        in_fire;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] load_data;
    logic        misaligned;
    logic [15:0] excp_all;

    assign in_ready = ~out_valid | out_ready;  // empty or being drained
    assign in_fire  = in_valid & in_ready;

    // byte lane / half lane picked by the low address bits
    assign sel_byte = in_bus.raw_data[{in_bus.addr_lo, 3'b000} +: 8];
    assign sel_half = in_bus.addr_lo[1] ? in_bus.raw_data[31:16] : in_bus.raw_data[15:0];

    always_comb begin
        unique case (in_bus.load_op)
            pipe_pkg::op_lb:  load_data = {{24{sel_byte[7]}}, sel_byte};
            pipe_pkg::op_lbu: load_data = {24'h0, sel_byte};
            pipe_pkg::op_lh:  load_data = {{16{sel_half[15]}}, sel_half};
            pipe_pkg::op_lhu: load_data = {16'h0, sel_half};
            default:          load_data = in_bus.raw_data;  // lw and non-loads
        endcase
    end

    // word needs both low bits clear, half needs bit 0 clear
    always_comb begin
        misaligned = 1'b0;
        if (in_bus.load_op == pipe_pkg::op_lw) begin
            misaligned = (in_bus.addr_lo != 2'b00);
        end else if (in_bus.load_op == pipe_pkg::op_lh || in_bus.load_op == pipe_pkg::op_lhu) begin
            misaligned = in_bus.addr_lo[0];
        end
    end

    always_comb begin
        excp_all = in_bus.excp_num;
        excp_all[csr_pkg::excp_bit_ale] = in_bus.excp_num[csr_pkg::excp_bit_ale] | misaligned;
    end

    // one-entry stage, valid flag
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // taken, nothing behind it
        end
    end

    // payload, held while out_ready is low
    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_ctrl.is_break   <= in_bus.is_break;
            out_ctrl.inst_valid <= in_bus.inst_valid;
            out_ctrl.wreg_index <= in_bus.wreg_index;
            out_ctrl.wreg_en    <= in_bus.wreg_en;
            out_ctrl.inst       <= in_bus.inst;
            out_ctrl.pc         <= in_bus.pc;
            out_ctrl.mem_result <= load_data;
            out_excp.ertn       <= in_bus.ertn;
            out_excp.excp_num   <= excp_all;
            out_excp.ms_excp    <= |excp_all;
            out_csr             <= in_csr;
        end
    end

endmodule

/* pipe_pkg.sv */
package pipe_pkg;

    // load extraction selected in the load-result stage
    typedef enum logic [2:0] {
        op_none = 3'd0,  // not a load, raw_data passes through
        op_lw   = 3'd1,
        op_lh   = 3'd2,
        op_lhu  = 3'd3,
        op_lb   = 3'd4,
        op_lbu  = 3'd5
    } load_op_t;

    // result as it leaves the memory stage
    typedef struct packed {
        logic        is_break;
        logic        inst_valid;
        logic [4:0]  wreg_index;
        logic        wreg_en;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] raw_data;   // load word or alu result
        logic [1:0]  addr_lo;    // low address bits of the access
        load_op_t    load_op;
        logic [15:0] excp_num;   // one bit per exception source
        logic        ertn;
    } mem_in_t;

    // aligned result, 104 bits
    // also the commit bus out of the writeback stage
    typedef struct packed {
        logic        is_break;
        logic        inst_valid;
        logic [4:0]  wreg_index;
        logic        wreg_en;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] mem_result;
    } mem_ctrl_t;

    // exception info travelling alongside mem_ctrl_t
    typedef struct packed {
        logic        ertn;
        logic [15:0] excp_num;
        logic        ms_excp;    // or of all excp_num bits
    } mem_excp_t;

    // forwarding path back to decode
    typedef struct packed {
        logic        wreg_en;
        logic [4:0]  wreg_index;
        logic [31:0] data;
    } bypass_t;

endpackage

/* regfile.sv */
module regfile (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read ports, r0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'h0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'h0 : regs[raddr2];

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int period       = 4,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // released just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

/* wb_stage.sv */
module wb_stage (
    input  logic                 clk,
    input  logic                 reset,
    // buses from the load-result stage
    input  pipe_pkg::mem_ctrl_t  mem_ctrl_bus,
    input  csr_pkg::csr_ctrl_t   mem_csr_bus,
    input  pipe_pkg::mem_excp_t  mem_excp_bus,
    // handshake
    input  logic                 left_valid,
    output logic                 left_ready,
    output logic                 right_valid,
    input  logic                 right_ready,
    // commit side
    output pipe_pkg::mem_ctrl_t  wb_ctrl_bus,
    output csr_pkg::csr_ctrl_t   wb_csr_bus,
    // exception
    output logic                 excp_flush,
    output logic                 ertn_flush,
    output logic [31:0]          excp_era,
    output logic [5:0]           ecode,
    output logic [8:0]           esubcode,
    // forwarding
    output pipe_pkg::bypass_t    wb_bypass,
    output csr_pkg::csr_ctrl_t   wb_csr_bypass
);

    logic ms_fire;      // transfer from the load-result stage
    logic commit_fire;  // transfer out of the commit register
    logic valid;
    logic excepting;

    assign left_ready  = right_ready;  // single slot, drains when downstream takes
    assign ms_fire     = left_valid & right_ready;
    assign right_valid = valid;
    assign commit_fire = valid & right_ready;

    assign excepting  = mem_excp_bus.ms_excp & mem_ctrl_bus.inst_valid;
    assign excp_flush = excepting & ms_fire;
    assign ertn_flush = mem_excp_bus.ertn & mem_ctrl_bus.inst_valid & ms_fire;
    assign excp_era   = mem_ctrl_bus.pc;

    // lowest set source wins, esubcode unused so far
    always_comb begin
        ecode    = 6'h0;
        esubcode = 9'h0;
        if (mem_excp_bus.excp_num[csr_pkg::excp_bit_sys]) begin
            ecode = csr_pkg::ecode_sys;
        end else if (mem_excp_bus.excp_num[csr_pkg::excp_bit_brk]) begin
            ecode = csr_pkg::ecode_brk;
        end else if (mem_excp_bus.excp_num[csr_pkg::excp_bit_ine]) begin
            ecode = csr_pkg::ecode_ine;
        end else if (mem_excp_bus.excp_num[csr_pkg::excp_bit_ipe]) begin
            ecode = csr_pkg::ecode_ipe;
        end else if (mem_excp_bus.excp_num[csr_pkg::excp_bit_ale]) begin
            ecode = csr_pkg::ecode_ale;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (ms_fire) begin
            valid <= 1'b1;
        end else if (commit_fire) begin
            valid <= 1'b0;
        end
    end

    // commit register
    always_ff @(posedge clk) begin
        if (ms_fire) begin
            wb_ctrl_bus <= mem_ctrl_bus;
            wb_csr_bus  <= mem_csr_bus;
            if (excepting) begin
                wb_ctrl_bus.wreg_en <= 1'b0;  // no rf write for a faulting inst
                wb_csr_bus.csr_we   <= 1'b0;  // nor a csr write
            end
        end
    end

    // forward straight from the incoming bus
    always_comb begin
        wb_bypass.wreg_en    = mem_ctrl_bus.wreg_en & left_valid;
        wb_bypass.wreg_index = mem_ctrl_bus.wreg_index;
        wb_bypass.data       = mem_ctrl_bus.mem_result;
        wb_csr_bypass        = mem_csr_bus;
        wb_csr_bypass.csr_we = mem_csr_bus.csr_we & left_valid;
    end

endmodule

/* wb_subsystem.f */
pipe_pkg.sv
csr_pkg.sv
mem_load_align.sv
wb_stage.sv
regfile.sv
csr_file.sv
wb_subsystem.sv
tb_clock_gen.sv
wb_subsystem_tb.sv

/* wb_subsystem.sv */
module wb_subsystem #(
    parameter logic [31:0] eentry_reset = 32'h1c00_8000
) (
    input  logic                 clk,
    input  logic                 reset,
    // memory-stage input
    input  logic                 in_valid,
    output logic                 in_ready,
    input  pipe_pkg::mem_in_t    in_bus,
    input  csr_pkg::csr_ctrl_t   in_csr,
    // commit
    output logic                 commit_valid,
    input  logic                 commit_ready,
    output pipe_pkg::mem_ctrl_t  commit_ctrl,
    // redirect
    output logic                 redirect_valid,
    output logic [31:0]          redirect_pc,
    // decode-side reads
    input  logic [4:0]           rf_raddr1,
    input  logic [4:0]           rf_raddr2,
    output logic [31:0]          rf_rdata1,
    output logic [31:0]          rf_rdata2,
    input  logic [13:0]          csr_rd_num,
    output logic [31:0]          csr_rd_data,
    // forwarding
    output pipe_pkg::bypass_t    wb_bypass,
    output csr_pkg::csr_ctrl_t   wb_csr_bypass
);

    logic                ms_valid;
    logic                ms_ready;
    pipe_pkg::mem_ctrl_t ms_ctrl;
    pipe_pkg::mem_excp_t ms_excp;
    csr_pkg::csr_ctrl_t  ms_csr;
    csr_pkg::csr_ctrl_t  wb_csr;
    logic                excp_flush;
    logic                ertn_flush;
    logic [31:0]         excp_era;
    logic [5:0]          ecode;
    logic [8:0]          esubcode;
    logic                commit_fire;

    assign commit_fire    = commit_valid & commit_ready;
    assign redirect_valid = excp_flush | ertn_flush;

    mem_load_align load_align_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_bus    (in_bus),
        .in_csr    (in_csr),
        .out_valid (ms_valid),
        .out_ready (ms_ready),
        .out_ctrl  (ms_ctrl),
        .out_excp  (ms_excp),
        .out_csr   (ms_csr)
    );

    wb_stage wb_i (
        .clk           (clk),
        .reset         (reset),
        .mem_ctrl_bus  (ms_ctrl),
        .mem_csr_bus   (ms_csr),
        .mem_excp_bus  (ms_excp),
        .left_valid    (ms_valid),
        .left_ready    (ms_ready),
        .right_valid   (commit_valid),
        .right_ready   (commit_ready),
        .wb_ctrl_bus   (commit_ctrl),
        .wb_csr_bus    (wb_csr),
        .excp_flush    (excp_flush),
        .ertn_flush    (ertn_flush),
        .excp_era      (excp_era),
        .ecode         (ecode),
        .esubcode      (esubcode),
        .wb_bypass     (wb_bypass),
        .wb_csr_bypass (wb_csr_bypass)
    );

    // write lands on commit fire
    regfile rf_i (
        .clk    (clk),
        .we     (commit_fire & commit_ctrl.wreg_en),
        .waddr  (commit_ctrl.wreg_index),
        .wdata  (commit_ctrl.mem_result),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    csr_file #(
        .eentry_reset (eentry_reset)
    ) csr_i (
        .clk         (clk),
        .reset       (reset),
        .csr_wr      (wb_csr),
        .csr_commit  (commit_fire),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .excp_era    (excp_era),
        .ecode       (ecode),
        .esubcode    (esubcode),
        .rd_num      (csr_rd_num),
        .rd_data     (csr_rd_data),
        .redirect_pc (redirect_pc)
    );

endmodule

/* wb_subsystem_tb.sv */
module wb_subsystem_tb;

    localparam logic [31:0] eentry_init = 32'h1c00_8000;
    localparam int n_items       = 400;
    localparam int free_items    = 100;  // no commit stalls while these enter
    localparam int max_stall     = 6;
    localparam int clk_period    = 4;
    localparam int watchdog_time = (n_items * (max_stall + 6) + 20) * clk_period;

    // csr numbers used for reads and writes, last one is not implemented
    localparam logic [13:0] csr_nums [6] = '{csr_pkg::csr_num_crmd, csr_pkg::csr_num_prmd,
        csr_pkg::csr_num_estat, csr_pkg::csr_num_era, csr_pkg::csr_num_eentry, 14'h7};
    // ecode for excp_num bits 5 up to 9
    localparam logic [5:0] code_by_bit [5] = '{csr_pkg::ecode_sys, csr_pkg::ecode_brk,
        csr_pkg::ecode_ine, csr_pkg::ecode_ipe, csr_pkg::ecode_ale};

    // one in-flight instruction as the model sees it
    typedef struct packed {
        logic [31:0]        pc;
        logic [31:0]        inst;
        logic [31:0]        result;
        logic [1:0]         flags;        // is_break, inst_valid
        logic               raw_wreg_en;  // as seen on the bypass
        logic               wreg_en;      // after suppression
        logic [4:0]         wreg_index;
        logic               excp;
        logic               ertn;
        logic [5:0]         ecode;
        csr_pkg::csr_ctrl_t csr;
        logic [31:0]        entry_cycle;
        logic               lat_ok;       // commit_ready stayed high since entry
    } exp_item_t;

    logic                clk;
    logic                reset;
    logic                in_valid;
    logic                in_ready;
    pipe_pkg::mem_in_t   in_bus;
    csr_pkg::csr_ctrl_t  in_csr;
    logic                commit_valid;
    logic                commit_ready;
    pipe_pkg::mem_ctrl_t commit_ctrl;
    logic                redirect_valid;
    logic [31:0]         redirect_pc;
    logic [4:0]          rf_raddr1;
    logic [4:0]          rf_raddr2;
    logic [31:0]         rf_rdata1;
    logic [31:0]         rf_rdata2;
    logic [13:0]         csr_rd_num;
    logic [31:0]         csr_rd_data;
    pipe_pkg::bypass_t   wb_bypass;
    csr_pkg::csr_ctrl_t  wb_csr_bypass;

    // model state
    logic [31:0] rf_model [32];
    logic [31:0] rf_written;
    logic [31:0] m_crmd;
    logic [31:0] m_prmd;
    logic [31:0] m_era;
    logic [31:0] m_eentry;
    logic [31:0] m_estat;
    logic        m_wb_valid;  // commit register occupied
    exp_item_t   exp_q [$];
    logic [31:0] cycle;
    logic [4:0]  last_wr;
    logic        pending;
    int          n_sent;
    int          n_done;
    int          stall_left;

    tb_clock_gen #(
        .period       (clk_period),
        .reset_cycles (5)
    ) clock_i (
        .clk   (clk),
        .reset (reset)
    );

    wb_subsystem #(
        .eentry_reset (eentry_init)
    ) dut_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_bus         (in_bus),
        .in_csr         (in_csr),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_ctrl    (commit_ctrl),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .csr_rd_num     (csr_rd_num),
        .csr_rd_data    (csr_rd_data),
        .wb_bypass      (wb_bypass),
        .wb_csr_bypass  (wb_csr_bypass)
    );

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR @%0t: %s is %h, expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] load_value(input pipe_pkg::mem_in_t b);
        logic [31:0] byte_w;
        logic [31:0] half_w;
        logic [31:0] val;
        byte_w = b.raw_data >> (8 * b.addr_lo);   // selected byte in [7:0]
        half_w = b.raw_data >> (16 * b.addr_lo[1]);
        case (b.load_op)
            pipe_pkg::op_lb:  val = {{24{byte_w[7]}}, byte_w[7:0]};
            pipe_pkg::op_lbu: val = {24'h0, byte_w[7:0]};
            pipe_pkg::op_lh:  val = {{16{half_w[15]}}, half_w[15:0]};
            pipe_pkg::op_lhu: val = {16'h0, half_w[15:0]};
            default:          val = b.raw_data;
        endcase
        return val;
    endfunction

    function automatic logic [5:0] excp_code(input logic [15:0] bits);
        logic [5:0] code;
        code = 6'h0;
        // walk downwards so the lowest set source is written last
        for (int i = 4; i >= 0; i--) begin
            if (bits[csr_pkg::excp_bit_sys + i]) begin
                code = code_by_bit[i];
            end
        end
        return code;
    endfunction

    function automatic logic [31:0] csr_model_value(input logic [13:0] num);
        logic [31:0] val;
        val = 32'h0;
        if (num == csr_pkg::csr_num_crmd) val = m_crmd;
        if (num == csr_pkg::csr_num_prmd) val = m_prmd;
        if (num == csr_pkg::csr_num_estat) val = m_estat;
        if (num == csr_pkg::csr_num_era) val = m_era;
        if (num == csr_pkg::csr_num_eentry) val = m_eentry;
        return val;
    endfunction

    function automatic exp_item_t make_expected(input pipe_pkg::mem_in_t b,
                                                input csr_pkg::csr_ctrl_t c);
        exp_item_t   e;
        logic [15:0] bits;
        logic        misaligned;
        misaligned = (b.load_op == pipe_pkg::op_lw && b.addr_lo != 2'b00) ||
                     ((b.load_op == pipe_pkg::op_lh || b.load_op == pipe_pkg::op_lhu) &&
                      b.addr_lo[0]);
        bits = b.excp_num;
        if (misaligned) begin
            bits[csr_pkg::excp_bit_ale] = 1'b1;
        end
        e.pc          = b.pc;
        e.inst        = b.inst;
        e.result      = load_value(b);
        e.flags       = {b.is_break, b.inst_valid};
        e.excp        = (bits != 16'h0) && b.inst_valid;
        e.ertn        = b.ertn && b.inst_valid;
        e.raw_wreg_en = b.wreg_en;
        e.wreg_en     = b.wreg_en && !e.excp;
        e.wreg_index  = b.wreg_index;
        e.ecode       = excp_code(bits);
        e.csr         = c;
        e.entry_cycle = cycle;
        e.lat_ok      = 1'b1;
        return e;
    endfunction

    task automatic random_item(output pipe_pkg::mem_in_t b, output csr_pkg::csr_ctrl_t c);
        logic [31:0] r;
        r = $urandom;
        b.is_break   = r[0];
        b.inst_valid = (r[3:1] != 3'd0);  // mostly valid
        b.wreg_en    = r[4];
        b.wreg_index = r[9:5];
        b.addr_lo    = r[20] ? r[11:10] : 2'b00;  // half of them aligned
        b.load_op    = pipe_pkg::load_op_t'(3'($urandom_range(5, 0)));
        b.ertn       = (r[15:12] == 4'd0);
        b.inst       = $urandom;
        b.pc         = $urandom & 32'hffff_fffc;
        b.raw_data   = $urandom;
        case (r[19:16])
            4'd0:    b.excp_num = 16'h0001 << $urandom_range(9, 5);  // single source
            4'd1:    b.excp_num = 16'($urandom) & 16'h03e0;          // priority mix
            4'd2:    b.excp_num = 16'h0001 << $urandom_range(4, 0);  // not decoded
            default: b.excp_num = 16'h0;
        endcase
        c.csr_we  = r[21];
        c.csr_op  = csr_pkg::csr_op_t'(2'($urandom_range(2, 0)));
        c.csr_num = csr_nums[$urandom_range(5, 0)];
        c.wdata   = $urandom;
        c.wmask   = $urandom;
    endtask

    task automatic drive_inputs();
        if (!pending && n_sent < n_items && $urandom_range(3, 0) != 0) begin
            random_item(in_bus, in_csr);
            pending = 1'b1;
        end
        in_valid = pending;  // held until the transfer
        if (n_sent < free_items) begin
            commit_ready = 1'b1;
        end else if (stall_left != 0) begin
            commit_ready = 1'b0;
            stall_left--;
        end else begin
            commit_ready = 1'b1;
            if ($urandom_range(7, 0) == 0) begin
                stall_left = $urandom_range(max_stall, 1);
            end
        end
        rf_raddr1  = last_wr;  // register touched by the latest commit
        rf_raddr2  = 5'($urandom_range(31, 0));
        csr_rd_num = csr_nums[$urandom_range(5, 0)];
    endtask

    // sampled at the falling edge, everything settled
    task automatic check_cycle();
        exp_item_t   ms_item;
        exp_item_t   front;
        exp_item_t   tmp;
        logic        ms_present;
        logic        redir_exp;
        logic [31:0] old_crmd;
        logic [31:0] old_prmd;
        logic [31:0] wr_old;
        logic [31:0] wr_val;
        int          ms_idx;

        check_eq("rf read port 1", rf_rdata1, rf_model[rf_raddr1]);
        if (rf_written[rf_raddr2] || rf_raddr2 == 5'd0) begin
            check_eq("rf read port 2", rf_rdata2, rf_model[rf_raddr2]);
        end
        check_eq("csr read", csr_rd_data, csr_model_value(csr_rd_num));

        check_eq("commit_valid", 32'(commit_valid), 32'(m_wb_valid));
        ms_idx     = m_wb_valid ? 1 : 0;  // oldest entry sits in the commit register
        ms_present = exp_q.size() > ms_idx;  // load-result stage holds an entry
        ms_item    = ms_present ? exp_q[ms_idx] : '0;
        check_eq("in_ready", 32'(in_ready), 32'(!ms_present || commit_ready));
        check_eq("bypass wreg_en", 32'(wb_bypass.wreg_en), 32'(ms_present && ms_item.raw_wreg_en));
        check_eq("csr bypass we", 32'(wb_csr_bypass.csr_we), 32'(ms_present && ms_item.csr.csr_we));
        if (ms_present) begin
            check_eq("bypass data", wb_bypass.data, ms_item.result);
            check_eq("bypass index", 32'(wb_bypass.wreg_index), 32'(ms_item.wreg_index));
            check_eq("csr bypass op and num",
                     32'({wb_csr_bypass.csr_op, wb_csr_bypass.csr_num}),
                     32'({ms_item.csr.csr_op, ms_item.csr.csr_num}));
            check_eq("csr bypass wdata", wb_csr_bypass.wdata, ms_item.csr.wdata);
            check_eq("csr bypass wmask", wb_csr_bypass.wmask, ms_item.csr.wmask);
        end

        redir_exp = ms_present && commit_ready && (ms_item.excp || ms_item.ertn);
        check_eq("redirect_valid", 32'(redirect_valid), 32'(redir_exp));
        if (redir_exp) begin
            check_eq("redirect_pc", redirect_pc, ms_item.excp ? m_eentry : m_era);
        end

        old_crmd = m_crmd;
        old_prmd = m_prmd;
        if (m_wb_valid && commit_ready) begin
            front = exp_q.pop_front();
            check_eq("commit pc", commit_ctrl.pc, front.pc);
            check_eq("commit inst", commit_ctrl.inst, front.inst);
            check_eq("commit mem_result", commit_ctrl.mem_result, front.result);
            check_eq("commit flags",
                     32'({commit_ctrl.is_break, commit_ctrl.inst_valid, commit_ctrl.wreg_en}),
                     32'({front.flags, front.wreg_en}));
            if (front.lat_ok) begin
                check_eq("commit latency", cycle - front.entry_cycle, 32'd2);
            end
            if (front.wreg_en) begin
                check_eq("commit wreg_index", 32'(commit_ctrl.wreg_index), 32'(front.wreg_index));
                last_wr = front.wreg_index;
                if (front.wreg_index != 5'd0) begin
                    rf_model[front.wreg_index]   = front.result;
                    rf_written[front.wreg_index] = 1'b1;
                end
            end
            // faulting instructions drop their csr write
            if (front.csr.csr_we && !front.excp && front.csr.csr_op != csr_pkg::csr_op_none) begin
                wr_old = csr_model_value(front.csr.csr_num);
                wr_val = front.csr.wdata;
                if (front.csr.csr_op == csr_pkg::csr_op_xchg) begin
                    wr_val = (wr_old & ~front.csr.wmask) | (front.csr.wdata & front.csr.wmask);
                end
                if (front.csr.csr_num == csr_pkg::csr_num_crmd) m_crmd = wr_val;
                if (front.csr.csr_num == csr_pkg::csr_num_prmd) m_prmd = wr_val;
                if (front.csr.csr_num == csr_pkg::csr_num_era) m_era = wr_val;
                if (front.csr.csr_num == csr_pkg::csr_num_eentry) m_eentry = wr_val;
            end
            n_done++;
        end

        // entry and return win over a write landing in the same cycle
        if (redir_exp && ms_item.excp) begin
            m_prmd[2:0]    = old_crmd[2:0];
            m_crmd[2:0]    = 3'b000;
            m_era          = ms_item.pc;
            m_estat[21:16] = ms_item.ecode;
            m_estat[30:22] = 9'h0;
        end else if (redir_exp) begin
            m_crmd[2:0] = old_prmd[2:0];
        end

        // commit register fills on an ms transfer, empties on a bare commit
        if (ms_present && commit_ready) begin
            m_wb_valid = 1'b1;
        end else if (commit_ready) begin
            m_wb_valid = 1'b0;
        end

        if (!commit_ready) begin
            for (int i = 0; i < exp_q.size(); i++) begin
                tmp        = exp_q[i];
                tmp.lat_ok = 1'b0;
                exp_q[i]   = tmp;
            end
        end
        if (in_valid && in_ready) begin
            exp_q.push_back(make_expected(in_bus, in_csr));
            pending = 1'b0;
            n_sent++;
        end
    endtask

    // drive after the edge, check once settled
    task automatic run_cycle();
        @(posedge clk);
        #1;
        drive_inputs();
        #1;
        check_cycle();
        cycle = cycle + 1;
    endtask

    initial begin
        void'($urandom(80));
        in_valid     = 1'b0;
        in_bus       = '0;
        in_csr       = '0;
        commit_ready = 1'b1;
        rf_raddr1    = 5'd0;
        rf_raddr2    = 5'd0;
        csr_rd_num   = 14'h0;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = 32'h0;
        end
        rf_written = 32'h0;
        m_crmd     = 32'h0;
        m_prmd     = 32'h0;
        m_era      = 32'h0;
        m_eentry   = eentry_init;
        m_estat    = 32'h0;
        m_wb_valid = 1'b0;
        cycle      = 32'h0;
        last_wr    = 5'd0;
        pending    = 1'b0;
        n_sent     = 0;
        n_done     = 0;
        stall_left = 0;

        @(negedge reset);
        @(negedge clk);
        check_eq("commit_valid after reset", 32'(commit_valid), 0);
        check_eq("redirect_valid after reset", 32'(redirect_valid), 0);

        while (n_done < n_items) begin
            run_cycle();
        end
        // idle tail, no extra commit may show up
        repeat (3) begin
            run_cycle();
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // bounded by every instruction waiting out a full stall
    initial begin
        #(watchdog_time);
        $display("timeout: only %0d of %0d instructions committed", n_done, n_items);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
